/* sim.f */
source/ps2_pkg.sv
source/ps2_line_filter.sv
source/ps2_frame_rx.sv
source/ps2_port.sv
source/switch_mode.sv
testbench/switch_mode_sva.sv
testbench/switch_mode_tb.sv

/* Bender.yml */
package:
  name: switch_mode

sources:
  - source/ps2_pkg.sv
  - source/ps2_line_filter.sv
  - source/ps2_frame_rx.sv
  - source/ps2_port.sv
  - source/switch_mode.sv
  - target: test
    files:
      - testbench/switch_mode_sva.sv
      - testbench/switch_mode_tb.sv

/* testbench/switch_mode_tb.sv */
`timescale 1ns/1ns

module switch_mode_tb;

  import ps2_pkg::*;

  localparam time drive_dly     = 5;   // after the rising edge
  localparam int  ps2_half      = 20;  // system cycles per ps2 clock phase
  localparam int  bit_cycles    = 2 * ps2_half;
  localparam int  settle_cycles = 40;
  localparam int  n_frames      = 39;  // frames over all tests
  localparam int  n_checks      = 15;  // settle windows over all tests
  localparam int  cycle_limit   =
    (n_frames * frame_bits * bit_cycles + n_checks * settle_cycles
     + frame_timeout_cycles + 300) * 3 / 2;

  logic        clk;
  logic        arst_n;
  logic        ps2_clk;
  logic        ps2_data;
  mode_state_t mode;
  test_start_t test_start;
  logic [3:0]  start_bits;   // [3] sram .. [0] mouse
  logic [3:0]  start_prev;

  integer      seed;
  mode_state_t exp_mode;     // model of the levels
  int          exp_pulses [4];
  int          obs_pulses [4];
  int          test_errs;
  int          tests_passed;
  int          tests_failed;
  int          cycle_cnt = 0;

  switch_mode i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .mode       (mode),
    .test_start (test_start)
  );

  always #50 clk = ~clk;

  assign start_bits = test_start;

  // rising pulses seen on each start bit
  always @(negedge clk) begin
    if (!arst_n) begin
      start_prev = '0;
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (start_bits[b] && !start_prev[b]) begin
          obs_pulses[b]++;
        end
      end
      start_prev = start_bits;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #drive_dly;  // drive point after the edge
  endtask

  // one frame as a keyboard sends it, lsb first
  task automatic send_byte(input logic [7:0] b, input bit bad_parity = 1'b0,
                           input int n_bits = 11);
    logic [10:0] frame;
    logic        parity;
    int          gap;
    int          i;
    parity = (~^b) ^ bad_parity;  // odd over data and parity
    frame  = {1'b1, parity, b, 1'b0};
    gap    = 4 + ($unsigned($random(seed)) % 16);
    wait_cycles(gap);
    ps2_data = frame[0];  // start bit ahead of the first fall
    wait_cycles(ps2_half);
    for (i = 0; i < n_bits; i++) begin
      ps2_clk = 1'b0;
      wait_cycles(ps2_half / 2);
      if (i + 1 < n_bits) begin
        ps2_data = frame[i+1];  // mid low phase
      end
      wait_cycles(ps2_half / 2);
      ps2_clk = 1'b1;
      wait_cycles(ps2_half);
    end
    ps2_data = 1'b1;  // idle
  endtask

  task automatic press_key(input logic [7:0] code, input bit ext = 1'b0);
    if (ext) begin
      send_byte(code_ext);
    end
    send_byte(code);
  endtask

  task automatic release_key(input logic [7:0] code, input bit ext = 1'b0);
    if (ext) begin
      send_byte(code_ext);
    end
    send_byte(code_brk);
    send_byte(code);
  endtask

  // main row or keypad code of a digit, chosen at random
  function automatic logic [7:0] pick_code(input int digit);
    bit kp;
    kp = ($random(seed) & 1) != 0;
    case (digit)
      1: return kp ? code_kp1 : code_key1;
      2: return kp ? code_kp2 : code_key2;
      3: return kp ? code_kp3 : code_key3;
      4: return kp ? code_kp4 : code_key4;
      5: return kp ? code_kp5 : code_key5;
      6: return kp ? code_kp6 : code_key6;
      default: return 8'h00;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks and report
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_state();
    int b;
    wait_cycles(settle_cycles);  // well past the 13 cycle path
    assert (mode == exp_mode) else begin
      $display("error: time %0t signal mode expected %b actual %b",
               $time, exp_mode, mode);
      test_errs++;
    end
    for (b = 0; b < 4; b++) begin
      assert (obs_pulses[b] == exp_pulses[b]) else begin
        $display("error: time %0t signal test_start[%0d] pulses expected %0d actual %0d",
                 $time, b, exp_pulses[b], obs_pulses[b]);
        test_errs++;
      end
    end
  endtask

  task automatic report_test(input string name);
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d checks failed", name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    int b;
    int k;
    clk          = 1'b0;
    arst_n       = 1'b0;
    ps2_clk      = 1'b1;  // idle bus
    ps2_data     = 1'b1;
    seed         = 32'h33d3;
    exp_mode     = '0;
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (b = 0; b < 4; b++) begin
      exp_pulses[b] = 0;
      obs_pulses[b] = 0;
    end
    repeat (3) @(posedge clk);
    #drive_dly;
    arst_n = 1'b1;

    // idle lines after reset
    wait_cycles(200);
    check_state();
    report_test("reset idle");

    // space bar level, extended space ignored
    press_key(code_space);
    exp_mode.hide_text = 1'b1;
    check_state();
    release_key(code_space, 1'b1);
    check_state();
    release_key(code_space);
    exp_mode.hide_text = 1'b0;
    check_state();
    press_key(code_space, 1'b1);
    check_state();
    report_test("space bar");

    // snes toggles on release only
    release_key(pick_code(1));
    exp_mode.snes1 = ~exp_mode.snes1;
    check_state();
    press_key(pick_code(1));  // press alone
    check_state();
    release_key(pick_code(1));
    exp_mode.snes1 = ~exp_mode.snes1;
    check_state();
    release_key(pick_code(2));
    exp_mode.snes2 = ~exp_mode.snes2;
    check_state();
    release_key(pick_code(2));
    exp_mode.snes2 = ~exp_mode.snes2;
    check_state();
    report_test("snes toggles");

    // keys 3 to 6 start sram, sdram, sd, mouse
    for (k = 3; k <= 6; k++) begin
      release_key(pick_code(k));
      exp_pulses[6-k]++;
    end
    check_state();
    release_key(code_kp4, 1'b1);  // left arrow, shares 6B
    release_key(code_kp6, 1'b1);  // right arrow, shares 74
    check_state();
    report_test("test starts");

    // pending break prefix wiped by a corrupted frame
    send_byte(code_brk);
    send_byte(code_brk, 1'b1);
    send_byte(code_key1);  // seen as a press
    check_state();
    release_key(code_key1);
    exp_mode.snes1 = ~exp_mode.snes1;
    check_state();
    report_test("parity error");

    // keyboard stops mid frame
    send_byte(code_key2, 1'b0, 5);
    wait_cycles(frame_timeout_cycles + 100);
    release_key(pick_code(2));
    exp_mode.snes2 = ~exp_mode.snes2;
    check_state();
    report_test("frame timeout");

    $display("tests passed %0d failed %0d, assertion failures %0d",
             tests_passed, tests_failed, i_dut.i_sva.fail_cnt);
    if (tests_failed == 0 && i_dut.i_sva.fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* testbench/switch_mode_sva.sv */
`timescale 1ns/1ns

module switch_mode_sva (
  input logic                 clk,
  input logic                 arst_n,
  input logic                 key_valid,
  input ps2_pkg::mode_state_t mode,
  input ps2_pkg::test_start_t test_start
);

  import ps2_pkg::*;

  int unsigned fail_cnt = 0;  // count of failed assertions
  logic [3:0]  start_bits;    // [3] sram .. [0] mouse

  assign start_bits = test_start;

  ////////////////////////////////////////////////////////////////////////////
  // output rules
  ////////////////////////////////////////////////////////////////////////////

  // quiet outputs while reset is held
  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> (mode == '0 && test_start == '0))
    else begin
      fail_cnt++;
      $error("mode or test_start not zero during reset");
    end

  for (genvar i = 0; i < 4; i++) begin : g_pulse
    // a start pulse lasts exactly one cycle
    a_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(start_bits[i]) |=> $fell(start_bits[i]))
      else begin
        fail_cnt++;
        $error("test_start bit %0d held longer than one cycle", i);
      end
  end

  // one self test started at a time
  a_one_test: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(start_bits))
    else begin
      fail_cnt++;
      $error("more than one test_start bit high");
    end

  // levels move only on the cycle after a key event
  a_mode_on_key: assert property (@(posedge clk) disable iff (!arst_n)
    !$stable(mode) |-> $past(key_valid))
    else begin
      fail_cnt++;
      $error("mode changed without a key event");
    end

endmodule

bind switch_mode switch_mode_sva i_sva (
  .clk        (clk),
  .arst_n     (arst_n),
  .key_valid  (key_valid),
  .mode       (mode),
  .test_start (test_start)
);

/* source/switch_mode.sv */
`timescale 1ns/1ns

module switch_mode (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 ps2_clk,
  input  logic                 ps2_data,
  output ps2_pkg::mode_state_t mode,
  output ps2_pkg::test_start_t test_start
);

  import ps2_pkg::*;

  logic     key_valid;
  ps2_key_t key;
  logic     plain_key;  // event without the E0 prefix
  logic     is_space;

  ////////////////////////////////////////////////////////////////////////////
  // keyboard receiver
  ////////////////////////////////////////////////////////////////////////////

  ps2_port i_port (
    .clk       (clk),
    .arst_n    (arst_n),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .key_valid (key_valid),
    .key       (key)
  );

  assign plain_key = key_valid && !key.extended;
  assign is_space  = (key.scancode == code_space);

  ////////////////////////////////////////////////////////////////////////////
  // key to mode and test start mapping
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mode       <= '0;
      test_start <= '0;
    end else begin
      test_start <= '0;  // pulses last one cycle

      if (plain_key && is_space) begin
        mode.hide_text <= ~key.released;  // high while space is held
      end else if (plain_key && key.released) begin
        // other keys act on release only
        case (key.scancode)
          code_key1, code_kp1: begin
            mode.snes1 <= ~mode.snes1;
          end
          code_key2, code_kp2: begin
            mode.snes2 <= ~mode.snes2;
          end
          code_key3, code_kp3: begin
            test_start.sram <= 1'b1;
          end
          code_key4, code_kp4: begin
            test_start.sdram <= 1'b1;
          end
          code_key5, code_kp5: begin
            test_start.sd <= 1'b1;
          end
          code_key6, code_kp6: begin
            test_start.mouse <= 1'b1;
          end
          default: begin
            // unmapped key, nothing to do
          end
        endcase
      end
    end
  end

endmodule

/* source/ps2_port.sv */
`timescale 1ns/1ns

module ps2_port (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              ps2_clk,
  input  logic              ps2_data,
  output logic              key_valid,
  output ps2_pkg::ps2_key_t key
);

  import ps2_pkg::*;

  logic       clk_fall;
  logic       data_filtered;
  logic       byte_valid;
  logic [7:0] rx_byte;
  logic       frame_error;

  logic       ext_pending;  // E0 received, waiting for the code
  logic       brk_pending;  // F0 received, waiting for the code
  logic       is_ext;
  logic       is_brk;
  logic       key_byte;     // a real scancode arrived this cycle

  ////////////////////////////////////////////////////////////////////////////
  // pins to bytes
  ////////////////////////////////////////////////////////////////////////////

  ps2_line_filter i_filter (
    .clk           (clk),
    .arst_n        (arst_n),
    .ps2_clk       (ps2_clk),
    .ps2_data      (ps2_data),
    .clk_fall      (clk_fall),
    .data_filtered (data_filtered)
  );

  ps2_frame_rx i_rx (
    .clk           (clk),
    .arst_n        (arst_n),
    .clk_fall      (clk_fall),
    .data_filtered (data_filtered),
    .byte_valid    (byte_valid),
    .rx_byte       (rx_byte),
    .frame_error   (frame_error)
  );

  ////////////////////////////////////////////////////////////////////////////
  // prefix folding
  ////////////////////////////////////////////////////////////////////////////

  assign is_ext   = (rx_byte == code_ext);
  assign is_brk   = (rx_byte == code_brk);
  assign key_byte = byte_valid && !is_ext && !is_brk;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ext_pending <= 1'b0;
      brk_pending <= 1'b0;
      key_valid   <= 1'b0;
    end else begin
      key_valid <= key_byte;  // prefixes never make an event
      if (frame_error) begin
        ext_pending <= 1'b0;  // a lost byte may have been part of the sequence
        brk_pending <= 1'b0;
      end else if (byte_valid) begin
        if (is_ext) begin
          ext_pending <= 1'b1;
        end else if (is_brk) begin
          brk_pending <= 1'b1;
        end else begin
          ext_pending <= 1'b0;  // event sent, start clean
          brk_pending <= 1'b0;
        end
      end
    end
  end

  // event payload, valid in the key_valid cycle only
  always_ff @(posedge clk) begin
    if (key_byte) begin
      key.scancode <= rx_byte;
      key.released <= brk_pending;
      key.extended <= ext_pending;
    end
  end

endmodule

/* source/ps2_frame_rx.sv */
`timescale 1ns/1ns

module ps2_frame_rx (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       clk_fall,
  input  logic       data_filtered,
  output logic       byte_valid,
  output logic [7:0] rx_byte,
  output logic       frame_error
);

  import ps2_pkg::*;

  logic [3:0]               bit_cnt;     // bits taken so far in this frame
  logic [frame_bits-1:0]    shift_q;     // lsb first, newest bit enters at the top
  logic [frame_bits-1:0]    frame_next;  // shift_q with the current bit added
  logic [timeout_cnt_w-1:0] idle_cnt;
  logic                     last_bit;    // the 11th falling edge
  logic                     start_ok;
  logic                     parity_ok;
  logic                     stop_ok;
  logic                     frame_ok;

  ////////////////////////////////////////////////////////////////////////////
  // frame assembly and checks
  ////////////////////////////////////////////////////////////////////////////

  assign frame_next = {data_filtered, shift_q[frame_bits-1:1]};
  assign last_bit   = clk_fall && (bit_cnt == 4'(frame_bits - 1));

  // layout after 11 bits: [0] start, [8:1] data, [9] parity, [10] stop
  assign start_ok  = ~frame_next[0];
  assign parity_ok = ^frame_next[9:1];  // odd parity over data and parity
  assign stop_ok   = frame_next[10];
  assign frame_ok  = start_ok && parity_ok && stop_ok;

  // payload registers
  always_ff @(posedge clk) begin
    if (clk_fall) begin
      shift_q <= frame_next;
    end
    if (last_bit) begin
      rx_byte <= frame_next[8:1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bit counter, idle timeout and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt     <= '0;
      idle_cnt    <= '0;
      byte_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      byte_valid  <= last_bit && frame_ok;   // one cycle after the last fall
      frame_error <= last_bit && !frame_ok;

      if (clk_fall) begin
        idle_cnt <= '0;
        if (last_bit) begin
          bit_cnt <= '0;  // frame done, wait for the next start bit
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if (bit_cnt != '0) begin
        // partial frame with a silent clock
        if (idle_cnt == timeout_max) begin
          bit_cnt  <= '0;  // drop it quietly, no strobe
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* source/ps2_line_filter.sv */
`timescale 1ns/1ns

module ps2_line_filter (
  input  logic clk,
  input  logic arst_n,
  input  logic ps2_clk,
  input  logic ps2_data,
  output logic clk_fall,
  output logic data_filtered
);

  import ps2_pkg::*;

  logic [1:0] pin_raw;   // [1] clock, [0] data
  logic [1:0] line_filt;
  logic       clk_filt;
  logic       clk_prev;  // filtered clock one cycle back

  assign pin_raw = {ps2_clk, ps2_data};

  ////////////////////////////////////////////////////////////////////////////
  // per line sync and glitch filter
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : g_line
    logic                    sync_q1;
    logic                    sync_q2;
    logic                    level_q;    // filtered level
    logic [filter_cnt_w-1:0] agree_cnt;  // samples that disagree with level_q

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        sync_q1   <= 1'b1;  // idle bus is high
        sync_q2   <= 1'b1;
        level_q   <= 1'b1;
        agree_cnt <= '0;
      end else begin
        sync_q1 <= pin_raw[i];
        sync_q2 <= sync_q1;
        if (sync_q2 == level_q) begin
          agree_cnt <= '0;  // glitch over, start again
        end else if (agree_cnt == filter_cnt_max) begin
          level_q   <= sync_q2;  // held long enough
          agree_cnt <= '0;
        end else begin
          agree_cnt <= agree_cnt + 1'b1;
        end
      end
    end

    assign line_filt[i] = level_q;
  end

  assign clk_filt      = line_filt[1];
  assign data_filtered = line_filt[0];

  // edge detect on the filtered clock
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_prev <= 1'b1;
    end else begin
      clk_prev <= clk_filt;
    end
  end

  assign clk_fall = clk_prev & ~clk_filt;  // same cycle as the filtered fall

endmodule

/* source/ps2_pkg.sv */
package ps2_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // line filter and frame timing
  ////////////////////////////////////////////////////////////////////////////

  // equal samples needed before a filtered line may flip
  localparam int unsigned filter_depth = 8;
  localparam int unsigned filter_cnt_w = $clog2(filter_depth);
  localparam logic [filter_cnt_w-1:0] filter_cnt_max = filter_cnt_w'(filter_depth - 1);

  // start + 8 data + parity + stop
  localparam int unsigned frame_bits = 11;

  // idle cycles inside a partial frame before it is thrown away
  localparam int unsigned frame_timeout_cycles = 2000;
  localparam int unsigned timeout_cnt_w = $clog2(frame_timeout_cycles);
  localparam logic [timeout_cnt_w-1:0] timeout_max =
    timeout_cnt_w'(frame_timeout_cycles - 1);

  ////////////////////////////////////////////////////////////////////////////
  // scancodes, set 2
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [7:0] code_ext = 8'he0;  // extended prefix
  localparam logic [7:0] code_brk = 8'hf0;  // break prefix

  localparam logic [7:0] code_space = 8'h29;

  // digit keys, main row and keypad
  localparam logic [7:0] code_key1 = 8'h16;
  localparam logic [7:0] code_kp1  = 8'h69;
  localparam logic [7:0] code_key2 = 8'h1e;
  localparam logic [7:0] code_kp2  = 8'h72;
  localparam logic [7:0] code_key3 = 8'h26;
  localparam logic [7:0] code_kp3  = 8'h7a;
  localparam logic [7:0] code_key4 = 8'h25;
  localparam logic [7:0] code_kp4  = 8'h6b;  // also E0 prefixed left arrow
  localparam logic [7:0] code_key5 = 8'h2e;
  localparam logic [7:0] code_kp5  = 8'h73;
  localparam logic [7:0] code_key6 = 8'h36;
  localparam logic [7:0] code_kp6  = 8'h74;  // also E0 prefixed right arrow

  ////////////////////////////////////////////////////////////////////////////
  // event and output types
  ////////////////////////////////////////////////////////////////////////////

  // one key event after prefix folding
  typedef struct packed {
    logic [7:0] scancode;
    logic       released;  // F0 seen before the code
    logic       extended;  // E0 seen before the code
  } ps2_key_t;

  // single cycle start pulses for the self tests
  typedef struct packed {
    logic sram;
    logic sdram;
    logic sd;
    logic mouse;
  } test_start_t;

  // level outputs
  typedef struct packed {
    logic snes1;
    logic snes2;
    logic hide_text;  // follows the space bar
  } mode_state_t;

endpackage
